// ==== verification/fu_vectors.txt ====
# op a b acc_len exp_res exp_rem_q, all hex
# ACC rows get b from the running sum, REM rows carry the quotient in rem_q
1 00000005 00000003 0000 00000008 00000000
1 7fffffff 00000001 0000 80000000 00000000
2 00000003 00000005 0000 fffffffe 00000000
2 80000000 00000001 0000 7fffffff 00000000
3 00000007 fffffffd 0000 ffffffeb 00000000
3 00010000 00010000 0000 00000000 00000000
4 00000001 0000001f 0000 80000000 00000000
4 0000ffff 00000024 0000 000ffff0 00000000
5 80000000 0000001f 0000 ffffffff 00000000
5 f0000000 00000000 0000 f0000000 00000000
6 80000000 0000001f 0000 00000001 00000000
6 f0000000 00000004 0000 0f000000 00000000
7 fffffffe 00000003 0000 fffffffe 00000000
7 00000005 80000000 0000 80000000 00000000
8 fffffffe 00000003 0000 00000003 00000000
8 7fffffff 80000000 0000 7fffffff 00000000
8 ffffff00 fffffff0 0000 fffffff0 00000000
9 fffffff6 00000000 0000 0000000a 00000000
9 80000000 00000000 0000 80000000 00000000
0 12345678 9abcdef0 0000 00000000 00000000
f 00000001 00000001 0000 00000000 00000000
a 00000005 00000000 0003 00000005 00000000
a 0000000a 00000000 0003 0000000f 00000000
a fffffffd 00000000 0003 0000000c 00000000
a 00000064 00000000 0003 00000070 00000000
b 00000064 00000007 0000 0000000e 00000002
b ffffff9c 00000007 0000 fffffff2 fffffffe
b 00000064 fffffff9 0000 fffffff2 00000002
b ffffff9c fffffff9 0000 0000000e fffffffe
b 12345678 00000000 0000 ffffffff 12345678
b ffffff9c 00000000 0000 ffffffff ffffff9c
b 80000000 ffffffff 0000 80000000 00000000
c ffffff9c 00000007 0000 fffffffe fffffff2
c 00000064 fffffff9 0000 00000002 fffffff2
c 80000000 ffffffff 0000 00000000 80000000
c 7fffffff 00010000 0000 0000ffff 00007fff

// ==== src.f ====
common/fu_pkg.sv
hw/fu_alu.sv
hw/fu_acc_ctrl.sv
divider/div_stage.sv
divider/div_pipe.sv
hw/fu_top.sv
verification/tb_fu_top.sv

// ==== Bender.yml ====
package:
  name: fu_top

sources:
  - common/fu_pkg.sv
  - hw/fu_alu.sv
  - hw/fu_acc_ctrl.sv
  - divider/div_stage.sv
  - divider/div_pipe.sv
  - hw/fu_top.sv
  - target: simulation
    files:
      - verification/tb_fu_top.sv

// ==== verification/tb_fu_top.sv ====
`timescale 1ns/100ps

module tb_fu_top;
  import fu_pkg::*;

  localparam int unsigned DIV_STAGE_BITS = 2;
  localparam int unsigned N_STAGES       = N_BITS / DIV_STAGE_BITS;
  // Passes of the DIV rows through the stalled stream
  localparam int unsigned STREAM_REPS    = 3;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic     clk_i;
  logic     rst_n_i;
  logic     ops_valid_i;
  logic     pea_ready_i;
  data_t    a_i;
  data_t    b_i;
  fu_op_e   instr_i;
  acc_len_t acc_len_i;
  logic     valid_o;
  logic     acc_loopback_o;
  data_t    res_o;
  data_t    rem_q_o;

  // Vector table
  fu_op_e      vec_op  [$];
  data_t       vec_a   [$];
  data_t       vec_b   [$];
  acc_len_t    vec_len [$];
  data_t       vec_res [$];
  data_t       vec_rem [$];
  int unsigned n_vec;

  // Division scoreboard, oldest first
  data_t       exp_res_q [$];
  data_t       exp_rem_q [$];
  data_t       pend_res;
  data_t       pend_rem;
  int unsigned n_sent;
  int unsigned n_recv;

  int unsigned val_errs;
  int unsigned proto_errs;
  logic [15:0] lfsr_q;
  fu_op_e      cur_op;
  // ACC run position and running sum
  int unsigned acc_idx;
  data_t       acc_sum;

  fu_top #(
    .DIV_STAGE_BITS(DIV_STAGE_BITS)
  ) fu_top_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ops_valid_i   (ops_valid_i),
    .pea_ready_i   (pea_ready_i),
    .a_i           (a_i),
    .b_i           (b_i),
    .instr_i       (instr_i),
    .acc_len_i     (acc_len_i),
    .valid_o       (valid_o),
    .acc_loopback_o(acc_loopback_o),
    .res_o         (res_o),
    .rem_q_o       (rem_q_o)
  );

  // 10 ns period
  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("ERROR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      val_errs++;
      $display("ERROR %s got %h exp %h", name, got, exp);
    end
  endtask

  function automatic logic is_div_op(input fu_op_e op);
    return (op == DIV) || (op == REM);
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_ready(output logic rdy);
    lfsr_q = lfsr_next(lfsr_q);
    rdy    = lfsr_q[0];
  endtask

  task automatic load_vectors;
    int                 fd;
    int                 code;
    int                 n;
    logic [8*128-1:0]   line;
    logic [3:0]         f_op;
    data_t              f_a;
    data_t              f_b;
    acc_len_t           f_len;
    data_t              f_res;
    data_t              f_rem;
    fd = $fopen("verification/fu_vectors.txt", "r");
    if (fd == 0) begin
      proto_errs++;
      $display("Cannot open the vector file");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // Header and blank lines do not parse as six fields
        if (code > 0) begin
          n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_a, f_b, f_len, f_res, f_rem);
          if (n == 6) begin
            vec_op.push_back(fu_op_e'(f_op));
            vec_a.push_back(f_a);
            vec_b.push_back(f_b);
            vec_len.push_back(f_len);
            vec_res.push_back(f_res);
            vec_rem.push_back(f_rem);
          end
        end
      end
      $fclose(fd);
    end
    n_vec = vec_op.size();
    if (n_vec == 0) begin
      proto_errs++;
      $display("No vectors were read");
    end
  endtask

  // Division results pop in order, accepted sets push afterwards
  task automatic observe_div;
    data_t e_res;
    data_t e_rem;
    if (is_div_op(instr_i)) begin
      if (valid_o && pea_ready_i) begin
        if (exp_res_q.size() == 0) begin
          proto_errs++;
          $display("Division result appeared with no division in flight");
        end else begin
          e_res = exp_res_q.pop_front();
          e_rem = exp_rem_q.pop_front();
          check_data("res_o", res_o, e_res);
          check_data("rem_q_o", rem_q_o, e_rem);
          n_recv++;
        end
      end
      if (ops_valid_i && pea_ready_i) begin
        exp_res_q.push_back(pend_res);
        exp_rem_q.push_back(pend_rem);
        n_sent++;
      end
    end
  endtask

  // Drive on the rising edge, look at outputs on the falling edge
  task automatic drive_cycle(input fu_op_e op, input data_t a, input data_t b,
                             input acc_len_t len, input logic vld, input logic rdy);
    @(posedge clk_i);
    instr_i     <= op;
    a_i         <= a;
    b_i         <= b;
    acc_len_i   <= len;
    ops_valid_i <= vld;
    pea_ready_i <= rdy;
    @(negedge clk_i);
    observe_div();
  endtask

  task automatic drain_div(input logic use_lfsr);
    int unsigned waited;
    logic        rdy;
    waited = 0;
    while (exp_res_q.size() != 0 && waited < (N_STAGES + 1) * 8) begin
      rdy = 1'b1;
      if (use_lfsr) begin
        draw_ready(rdy);
      end
      drive_cycle(cur_op, '0, '0, '0, 1'b0, rdy);
      waited++;
    end
    if (exp_res_q.size() != 0) begin
      proto_errs++;
      $display("%0d division results never came back", exp_res_q.size());
      exp_res_q.delete();
      exp_rem_q.delete();
    end
    // Quiet cycles catch duplicated results
    repeat (4) drive_cycle(cur_op, '0, '0, '0, 1'b0, 1'b1);
  endtask

  // Idle cycle then valid cycle, valid_o tracks ops_valid_i
  task automatic run_single(input int unsigned i);
    drive_cycle(vec_op[i], vec_a[i], vec_b[i], vec_len[i], 1'b0, 1'b1);
    check_flag("valid_o", valid_o, 1'b0);
    drive_cycle(vec_op[i], vec_a[i], vec_b[i], vec_len[i], 1'b1, 1'b1);
    check_flag("valid_o", valid_o, 1'b1);
    check_data("res_o", res_o, vec_res[i]);
    check_data("rem_q_o", rem_q_o, vec_rem[i]);
  endtask

  // One ACC element with the running sum looped back on b
  task automatic run_acc_element(input int unsigned i);
    drive_cycle(ACC, vec_a[i], acc_sum, vec_len[i], 1'b1, 1'b1);
    check_flag("acc_loopback_o", acc_loopback_o, acc_idx != 0);
    check_flag("valid_o", valid_o, acc_idx == vec_len[i]);
    check_data("res_o", res_o, vec_res[i]);
    if (acc_idx == vec_len[i]) begin
      acc_idx = 0;
      acc_sum = '0;
    end else begin
      acc_idx++;
      acc_sum = acc_sum + vec_a[i];
    end
  endtask

  task automatic finish_run;
    $display("Errors: %0d value, %0d protocol", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin
    wait (n_vec != 0);
    repeat (n_vec * (N_STAGES + 1) * 4) @(posedge clk_i);
    proto_errs++;
    $display("Watchdog expired before the tests finished");
    finish_run();
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic rdy;
    logic accepted;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    ops_valid_i = 1'b0;
    pea_ready_i = 1'b0;
    a_i         = '0;
    b_i         = '0;
    // Divider valid shows on valid_o during reset
    instr_i     = DIV;
    acc_len_i   = '0;
    val_errs    = 0;
    proto_errs  = 0;
    n_sent      = 0;
    n_recv      = 0;
    n_vec       = 0;
    lfsr_q      = 16'd2850;
    cur_op      = NOP;
    acc_idx     = 0;
    acc_sum     = '0;
    pend_res    = '0;
    pend_rem    = '0;
    load_vectors();

    // Outputs stay low through reset
    repeat (10) begin
      @(negedge clk_i);
      check_flag("valid_o", valid_o, 1'b0);
      check_flag("acc_loopback_o", acc_loopback_o, 1'b0);
    end
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Empty divider after reset
    drive_cycle(DIV, '0, '0, '0, 1'b0, 1'b1);
    check_flag("valid_o", valid_o, 1'b0);
    check_flag("acc_loopback_o", acc_loopback_o, 1'b0);
    cur_op = DIV;

    // Directed vectors with ready held high
    for (int unsigned i = 0; i < n_vec; i++) begin
      // Opcode only changes with the divider empty
      if (is_div_op(cur_op) && vec_op[i] != cur_op) begin
        drain_div(1'b0);
      end
      cur_op = vec_op[i];
      case (vec_op[i])
        DIV, REM: begin
          pend_res = vec_res[i];
          pend_rem = vec_rem[i];
          drive_cycle(vec_op[i], vec_a[i], vec_b[i], vec_len[i], 1'b1, 1'b1);
        end
        ACC:     run_acc_element(i);
        default: run_single(i);
      endcase
    end
    if (is_div_op(cur_op)) begin
      drain_div(1'b0);
    end

    // Back-to-back DIV stream under random back-pressure
    cur_op = DIV;
    for (int unsigned rep = 0; rep < STREAM_REPS; rep++) begin
      for (int unsigned i = 0; i < n_vec; i++) begin
        if (vec_op[i] == DIV) begin
          pend_res = vec_res[i];
          pend_rem = vec_rem[i];
          accepted = 1'b0;
          while (!accepted) begin
            draw_ready(rdy);
            drive_cycle(DIV, vec_a[i], vec_b[i], vec_len[i], 1'b1, rdy);
            accepted = rdy;
          end
        end
      end
    end
    drain_div(1'b1);

    if (n_sent != n_recv) begin
      proto_errs++;
      $display("%0d divisions accepted but %0d results returned", n_sent, n_recv);
    end
    finish_run();
  end

endmodule

// ==== hw/fu_top.sv ====
`timescale 1ns/100ps

module fu_top #(
  parameter int unsigned DIV_STAGE_BITS = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             ops_valid_i,
  input  logic             pea_ready_i,
  input  fu_pkg::data_t    a_i,
  input  fu_pkg::data_t    b_i,
  input  fu_pkg::fu_op_e   instr_i,
  input  fu_pkg::acc_len_t acc_len_i,
  output logic             valid_o,
  output logic             acc_loopback_o,
  output fu_pkg::data_t    res_o,
  output fu_pkg::data_t    rem_q_o
);
  import fu_pkg::*;

  // Decode
  fu_op_e alu_op;
  logic   is_acc;
  logic   is_div;
  logic   is_rem;
  // Block enables and returns
  logic   acc_en;
  logic   acc_valid;
  logic   div_in_valid;
  logic   div_valid;
  data_t  alu_res;
  data_t  div_q;
  data_t  div_r;

  ////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////

  always_comb begin
    alu_op = NOP;
    is_acc = 1'b0;
    is_div = 1'b0;
    is_rem = 1'b0;
    case (instr_i)
      ADD, SUB, MUL, LSH, ARSH, LRSH, MIN, MAX, ABS: begin
        alu_op = instr_i;
      end
      ACC: begin
        // Adder sums operand and loopback
        alu_op = ACC;
        is_acc = 1'b1;
      end
      DIV:     is_div = 1'b1;
      REM:     is_rem = 1'b1;
      // ALU idles at NOP and yields zero
      default: alu_op = NOP;
    endcase
  end

  assign acc_en       = is_acc;
  assign div_in_valid = ops_valid_i & (is_div | is_rem);

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  fu_alu fu_alu_inst (
    .instr_i(alu_op),
    .a_i    (a_i),
    .b_i    (b_i),
    .res_o  (alu_res)
  );

  fu_acc_ctrl fu_acc_ctrl_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .acc_en_i      (acc_en),
    .ops_valid_i   (ops_valid_i),
    .pea_ready_i   (pea_ready_i),
    .acc_len_i     (acc_len_i),
    .acc_valid_o   (acc_valid),
    .acc_loopback_o(acc_loopback_o)
  );

  div_pipe #(
    .DIV_STAGE_BITS(DIV_STAGE_BITS)
  ) div_pipe_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (div_in_valid),
    .pea_ready_i(pea_ready_i),
    .a_i        (a_i),
    .b_i        (b_i),
    .q_o        (div_q),
    .r_o        (div_r),
    .valid_o    (div_valid)
  );

  ////////////////////////////////////////
  // Valid and result muxing
  ////////////////////////////////////////

  // Single-cycle ops pass the input valid straight through
  assign valid_o = (is_div | is_rem) ? div_valid :
                   is_acc            ? acc_valid : ops_valid_i;

  always_comb begin
    res_o   = alu_res;
    rem_q_o = '0;
    if (is_div) begin
      res_o   = div_q;
      rem_q_o = div_r;
    end else if (is_rem) begin
      // Secondary result swaps to the quotient
      res_o   = div_r;
      rem_q_o = div_q;
    end
  end

endmodule

// ==== divider/div_pipe.sv ====
`timescale 1ns/100ps

module div_pipe #(
  parameter int unsigned DIV_STAGE_BITS = 2
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          in_valid_i,
  input  logic          pea_ready_i,
  input  fu_pkg::data_t a_i,
  input  fu_pkg::data_t b_i,
  output fu_pkg::data_t q_o,
  output fu_pkg::data_t r_o,
  output logic          valid_o
);
  import fu_pkg::*;

  localparam int unsigned N_STAGES = N_BITS / DIV_STAGE_BITS;
  localparam int unsigned LAST     = N_STAGES - 1;

  // Operand signs and magnitudes
  logic  a_neg;
  logic  b_neg;
  data_t a_abs;
  data_t b_abs;
  logic  b_zero;

  // Stage inputs
  data_t rem_in   [N_STAGES];
  data_t quo_in   [N_STAGES];
  data_t dvs_in   [N_STAGES];
  logic  neg_q_in [N_STAGES];
  logic  neg_r_in [N_STAGES];
  logic  dz_in    [N_STAGES];
  logic  vld_in   [N_STAGES];
  // Stage combinational outputs
  data_t rem_nxt  [N_STAGES];
  data_t quo_nxt  [N_STAGES];
  // Stage registers
  data_t rem_r    [N_STAGES];
  data_t quo_r    [N_STAGES];
  data_t dvs_r    [N_STAGES];
  logic  neg_q_r  [N_STAGES];
  logic  neg_r_r  [N_STAGES];
  logic  dz_r     [N_STAGES];
  logic  vld_r    [N_STAGES];
  // Sign fix-up
  data_t q_fix;
  data_t r_fix;

  assign a_neg  = a_i[N_BITS-1];
  assign b_neg  = b_i[N_BITS-1];
  assign a_abs  = a_neg ? -a_i : a_i;
  assign b_abs  = b_neg ? -b_i : b_i;
  assign b_zero = (b_i == '0);

  ////////////////////////////////////////
  // Stage chain
  ////////////////////////////////////////

  for (genvar k = 0; k < N_STAGES; k++) begin : g_stage
    if (k == 0) begin : g_head
      // Fresh division enters with empty remainder
      assign rem_in[k]   = '0;
      assign quo_in[k]   = a_abs;
      assign dvs_in[k]   = b_abs;
      assign neg_q_in[k] = a_neg ^ b_neg;
      assign neg_r_in[k] = a_neg;
      assign dz_in[k]    = b_zero;
      assign vld_in[k]   = in_valid_i;
    end else begin : g_link
      assign rem_in[k]   = rem_r[k-1];
      assign quo_in[k]   = quo_r[k-1];
      assign dvs_in[k]   = dvs_r[k-1];
      assign neg_q_in[k] = neg_q_r[k-1];
      assign neg_r_in[k] = neg_r_r[k-1];
      assign dz_in[k]    = dz_r[k-1];
      assign vld_in[k]   = vld_r[k-1];
    end

    div_stage #(
      .DIV_STAGE_BITS(DIV_STAGE_BITS)
    ) div_stage_inst (
      .rem_i    (rem_in[k]),
      .quo_i    (quo_in[k]),
      .divisor_i(dvs_in[k]),
      .rem_o    (rem_nxt[k]),
      .quo_o    (quo_nxt[k])
    );

    // Valid bit holds under back-pressure
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        vld_r[k] <= 1'b0;
      end else if (pea_ready_i) begin
        vld_r[k] <= vld_in[k];
      end
    end

    // Payload
    always_ff @(posedge clk_i) begin
      if (pea_ready_i) begin
        rem_r[k]   <= rem_nxt[k];
        quo_r[k]   <= quo_nxt[k];
        dvs_r[k]   <= dvs_in[k];
        neg_q_r[k] <= neg_q_in[k];
        neg_r_r[k] <= neg_r_in[k];
        dz_r[k]    <= dz_in[k];
      end
    end
  end

  ////////////////////////////////////////
  // Output fix-up
  ////////////////////////////////////////

  // Quotient truncates toward zero
  // Divide by zero gives all ones
  assign q_fix = dz_r[LAST] ? '1 : (neg_q_r[LAST] ? -quo_r[LAST] : quo_r[LAST]);
  // Remainder follows the dividend sign
  assign r_fix = neg_r_r[LAST] ? -rem_r[LAST] : rem_r[LAST];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else if (pea_ready_i) begin
      valid_o <= vld_r[LAST];
    end
  end

  always_ff @(posedge clk_i) begin
    if (pea_ready_i) begin
      q_o <= q_fix;
      r_o <= r_fix;
    end
  end

endmodule

// ==== divider/div_stage.sv ====
`timescale 1ns/100ps

module div_stage #(
  parameter int unsigned DIV_STAGE_BITS = 2
) (
  input  fu_pkg::data_t rem_i,
  input  fu_pkg::data_t quo_i,
  input  fu_pkg::data_t divisor_i,
  output fu_pkg::data_t rem_o,
  output fu_pkg::data_t quo_o
);
  import fu_pkg::*;

  // Partial remainder and dividend/quotient shift word
  data_t           rem;
  data_t           quo;
  // Remainder after shifting in one dividend bit
  logic [N_BITS:0] rem_ext;
  // Trial difference with borrow on top
  logic [N_BITS:0] diff;

  // Unsigned shift-subtract steps
  // Dividend bits leave at the top of quo
  // Quotient bits enter at the bottom
  always_comb begin
    rem     = rem_i;
    quo     = quo_i;
    rem_ext = '0;
    diff    = '0;
    for (int i = 0; i < DIV_STAGE_BITS; i++) begin
      rem_ext = {rem, quo[N_BITS-1]};
      quo     = {quo[N_BITS-2:0], 1'b0};
      diff    = rem_ext - {1'b0, divisor_i};
      if (!diff[N_BITS]) begin
        // Divisor fits
        rem    = diff[N_BITS-1:0];
        quo[0] = 1'b1;
      end else begin
        // Remainder stays below the divisor
        rem = rem_ext[N_BITS-1:0];
      end
    end
  end

  assign rem_o = rem;
  assign quo_o = quo;

endmodule

// ==== hw/fu_acc_ctrl.sv ====
`timescale 1ns/100ps

module fu_acc_ctrl (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             acc_en_i,
  input  logic             ops_valid_i,
  input  logic             pea_ready_i,
  input  fu_pkg::acc_len_t acc_len_i,
  output logic             acc_valid_o,
  output logic             acc_loopback_o
);
  import fu_pkg::*;

  // Elements taken so far in this run
  acc_len_t cnt_q;
  logic     accept;
  logic     run_end;

  // Operand set handed over this cycle
  assign accept = ops_valid_i & pea_ready_i;
  // Last element of the run
  assign run_end = (cnt_q == acc_len_i);

  // Counter and loopback flag
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q          <= '0;
      acc_loopback_o <= 1'b0;
    end else if (!acc_en_i) begin
      // Idle outside ACC
      cnt_q          <= '0;
      acc_loopback_o <= 1'b0;
    end else if (accept) begin
      if (run_end) begin
        // Run done so start over
        cnt_q          <= '0;
        acc_loopback_o <= 1'b0;
      end else begin
        cnt_q          <= cnt_q + acc_len_t'(1);
        acc_loopback_o <= 1'b1;
      end
    end
  end

  // Sum is complete on the last element
  assign acc_valid_o = ops_valid_i & run_end;

endmodule

// ==== hw/fu_alu.sv ====
`timescale 1ns/100ps

module fu_alu (
  input  fu_pkg::fu_op_e instr_i,
  input  fu_pkg::data_t  a_i,
  input  fu_pkg::data_t  b_i,
  output fu_pkg::data_t  res_o
);
  import fu_pkg::*;

  // Shared adder
  data_t               add_a;
  data_t               add_b;
  logic                add_cin;
  logic [N_BITS:0]     add_full;
  data_t               add_res;
  // Signed a < b
  logic                a_lt_b;
  // Multiplier
  data_t               mul_res;
  // Shifter
  logic [SHAMT_W-1:0]  shamt;
  data_t               a_rev;
  logic [2*N_BITS-1:0] shift_in;
  logic [2*N_BITS-1:0] shift_full;
  data_t               shift_res;
  data_t               lsh_res;

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  // Operand steering for ADD, ACC, SUB, MIN, MAX and ABS
  always_comb begin
    add_a   = a_i;
    add_b   = b_i;
    add_cin = 1'b0;
    case (instr_i)
      SUB, MIN, MAX: begin
        add_b   = ~b_i;
        add_cin = 1'b1;
      end
      ABS: begin
        // Zero minus a
        add_a   = '0;
        add_b   = ~a_i;
        add_cin = 1'b1;
      end
      default: begin
        add_cin = 1'b0;
      end
    endcase
  end

  // Carry-in enters through the extra low bit
  assign add_full = {add_a, add_cin} + {add_b, add_cin};
  assign add_res  = add_full[N_BITS:1];

  // Signs differ so a is smaller when negative
  assign a_lt_b = (a_i[N_BITS-1] != b_i[N_BITS-1]) ? a_i[N_BITS-1] : add_res[N_BITS-1];

  // Low word of the product
  assign mul_res = a_i * b_i;

  ////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////

  assign shamt = b_i[SHAMT_W-1:0];

  // Left shift goes through the right shifter on reversed bits
  always_comb begin
    for (int i = 0; i < N_BITS; i++) begin
      a_rev[i] = a_i[N_BITS-1-i];
    end
  end

  // Upper half supplies the fill bits
  always_comb begin
    case (instr_i)
      LSH:     shift_in = {{N_BITS{1'b0}}, a_rev};
      LRSH:    shift_in = {{N_BITS{1'b0}}, a_i};
      default: shift_in = {{N_BITS{a_i[N_BITS-1]}}, a_i};
    endcase
  end

  assign shift_full = shift_in >> shamt;
  assign shift_res  = shift_full[N_BITS-1:0];

  // Undo the reversal for LSH
  always_comb begin
    for (int i = 0; i < N_BITS; i++) begin
      lsh_res[i] = shift_res[N_BITS-1-i];
    end
  end

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    case (instr_i)
      ADD, ACC, SUB: res_o = add_res;
      MUL:           res_o = mul_res;
      LSH:           res_o = lsh_res;
      ARSH, LRSH:    res_o = shift_res;
      MIN:           res_o = a_lt_b ? a_i : b_i;
      MAX:           res_o = a_lt_b ? b_i : a_i;
      // Most negative value maps to itself
      ABS:           res_o = a_i[N_BITS-1] ? add_res : a_i;
      default:       res_o = '0;
    endcase
  end

endmodule

// ==== common/fu_pkg.sv ====
package fu_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Datapath width, one word
  localparam int unsigned N_BITS = 32;
  // Accumulation length, half a word
  localparam int unsigned ACC_LEN_W = 16;
  // Low operand-b bits used as shift amount
  localparam int unsigned SHAMT_W = 5;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Operand and result word
  typedef logic [N_BITS-1:0] data_t;
  // Accumulation run length
  typedef logic [ACC_LEN_W-1:0] acc_len_t;

  // Static opcode of the unit
  // Unlisted codes behave as NOP
  typedef enum logic [3:0] {
    NOP  = 4'd0,
    ADD  = 4'd1,
    SUB  = 4'd2,
    MUL  = 4'd3,
    LSH  = 4'd4,
    ARSH = 4'd5,
    LRSH = 4'd6,
    MIN  = 4'd7,
    MAX  = 4'd8,
    ABS  = 4'd9,
    ACC  = 4'd10,
    DIV  = 4'd11,
    REM  = 4'd12
  } fu_op_e;

endpackage
